/* ace_pkg.sv */
`default_nettype none

package ace_pkg;

    localparam int unsigned NUM_MST_PORTS = 4;
    localparam int unsigned MAX_TRANS     = 8;
    localparam int unsigned ID_WIDTH      = 4;
    localparam int unsigned DATA_WIDTH    = 32;

    // AW and AR
    localparam int unsigned NUM_REQ_CH    = 2;

    // Derived widths
    localparam int unsigned PORT_IDX_WIDTH = (NUM_MST_PORTS > 1) ? $clog2(NUM_MST_PORTS) : 1;
    localparam int unsigned FIFO_PTR_WIDTH = (MAX_TRANS > 1) ? $clog2(MAX_TRANS) : 1;
    localparam int unsigned FIFO_CNT_WIDTH = $clog2(MAX_TRANS + 1);

    // One downstream port
    typedef logic [PORT_IDX_WIDTH-1:0] port_idx_t;

    // One bit per downstream port
    typedef logic [NUM_MST_PORTS-1:0]  port_vec_t;

    typedef logic [ID_WIDTH-1:0]       axi_id_t;
    typedef logic [DATA_WIDTH-1:0]     axi_data_t;

    // Queue occupancy, 0 to MAX_TRANS
    typedef logic [FIFO_CNT_WIDTH-1:0] fifo_cnt_t;
    typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;

endpackage

`default_nettype wire

/* ace_ack_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module ace_ack_fifo
    import ace_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      push_i,
    input  port_idx_t data_i,
    input  logic      pop_i,
    output port_idx_t data_o,
    output logic      empty_o,
    output logic      full_o
);

    port_idx_t mem_q [MAX_TRANS];
    fifo_ptr_t rd_ptr_q;
    fifo_ptr_t wr_ptr_q;
    fifo_cnt_t cnt_q;
    logic      push_ok;
    logic      pop_ok;

    function automatic fifo_ptr_t ptr_inc(fifo_ptr_t p);
        if (p == fifo_ptr_t'(MAX_TRANS - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign empty_o = (cnt_q == '0);
    assign full_o  = (cnt_q == fifo_cnt_t'(MAX_TRANS));
    assign data_o  = mem_q[rd_ptr_q];

    // Pop on empty is dropped; push on full needs a pop in the same cycle
    assign pop_ok  = pop_i && !empty_o;
    assign push_ok = push_i && (!full_o || pop_ok);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_ok) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_ok, pop_ok})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

/* ace_resp_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ace_resp_arbiter
    import ace_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  port_vec_t valid_i,
    input  port_vec_t last_i,
    input  logic      accept_i,
    output port_idx_t grant_o,
    output logic      grant_valid_o
);

    port_idx_t rr_ptr_q;
    port_idx_t lock_idx_q;
    logic      locked_q;
    port_idx_t rr_grant;
    logic      rr_found;

    function automatic port_idx_t next_port(port_idx_t p);
        if (p == port_idx_t'(NUM_MST_PORTS - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // First valid port at or after the pointer
    always_comb begin
        port_idx_t idx;
        rr_grant = rr_ptr_q;
        rr_found = 1'b0;
        idx      = rr_ptr_q;
        for (int unsigned i = 0; i < NUM_MST_PORTS; i++) begin
            if (!rr_found && valid_i[idx]) begin
                rr_grant = idx;
                rr_found = 1'b1;
            end
            idx = next_port(idx);
        end
    end

    assign grant_o       = locked_q ? lock_idx_q : rr_grant;
    assign grant_valid_o = locked_q ? valid_i[lock_idx_q] : rr_found;

    // Lock on a stalled grant or on an accepted beat without last
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rr_ptr_q <= '0;
            locked_q <= 1'b0;
        end else if (accept_i) begin
            rr_ptr_q <= next_port(grant_o);
            locked_q <= !last_i[grant_o];
        end else if (grant_valid_o) begin
            locked_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant_valid_o) begin
            lock_idx_q <= grant_o;
        end
    end

endmodule

`default_nettype wire

/* ace_write_resp_path.sv */
`timescale 1ns/1ps
`default_nettype none

module ace_write_resp_path
    import ace_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  port_vec_t                    mst_b_valid_i,
    input  axi_id_t [NUM_MST_PORTS-1:0]  mst_b_id_i,
    output port_vec_t                    mst_b_ready_o,
    output logic                         slv_b_valid_o,
    input  logic                         slv_b_ready_i,
    output axi_id_t                      slv_b_id_o,
    input  logic                         slv_wack_i,
    output port_vec_t                    mst_wack_o
);

    port_idx_t grant;
    logic      grant_valid;
    logic      b_accept;
    port_idx_t head_idx;
    logic      fifo_empty;
    logic      fifo_full;

    // Every B is a single beat
    ace_resp_arbiter i_b_arb (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (mst_b_valid_i),
        .last_i        ({NUM_MST_PORTS{1'b1}}),
        .accept_i      (b_accept),
        .grant_o       (grant),
        .grant_valid_o (grant_valid)
    );

    assign slv_b_valid_o = grant_valid && !fifo_full;
    assign slv_b_id_o    = mst_b_id_i[grant];
    assign b_accept      = slv_b_valid_o && slv_b_ready_i;

    always_comb begin
        mst_b_ready_o        = '0;
        mst_b_ready_o[grant] = b_accept;
    end

    ace_ack_fifo i_b_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (b_accept),
        .data_i  (grant),
        .pop_i   (slv_wack_i),
        .data_o  (head_idx),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

    always_comb begin
        mst_wack_o           = '0;
        mst_wack_o[head_idx] = slv_wack_i && !fifo_empty;
    end

endmodule

`default_nettype wire

/* ace_read_resp_path.sv */
`timescale 1ns/1ps
`default_nettype none

module ace_read_resp_path
    import ace_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  port_vec_t                     mst_r_valid_i,
    input  axi_id_t   [NUM_MST_PORTS-1:0] mst_r_id_i,
    input  axi_data_t [NUM_MST_PORTS-1:0] mst_r_data_i,
    input  port_vec_t                     mst_r_last_i,
    output port_vec_t                     mst_r_ready_o,
    output logic                          slv_r_valid_o,
    input  logic                          slv_r_ready_i,
    output axi_id_t                       slv_r_id_o,
    output axi_data_t                     slv_r_data_o,
    output logic                          slv_r_last_o,
    input  logic                          slv_rack_i,
    output port_vec_t                     mst_rack_o
);

    port_idx_t grant;
    logic      grant_valid;
    logic      r_accept;
    logic      burst_done;
    port_idx_t head_idx;
    logic      fifo_empty;
    logic      fifo_full;

    // Burst lock keeps a port granted until its last beat goes through
    ace_resp_arbiter i_r_arb (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (mst_r_valid_i),
        .last_i        (mst_r_last_i),
        .accept_i      (r_accept),
        .grant_o       (grant),
        .grant_valid_o (grant_valid)
    );

    assign slv_r_valid_o = grant_valid && !fifo_full;
    assign slv_r_id_o    = mst_r_id_i[grant];
    assign slv_r_data_o  = mst_r_data_i[grant];
    assign slv_r_last_o  = mst_r_last_i[grant];
    assign r_accept      = slv_r_valid_o && slv_r_ready_i;
    assign burst_done    = r_accept && slv_r_last_o;

    always_comb begin
        mst_r_ready_o        = '0;
        mst_r_ready_o[grant] = r_accept;
    end

    ace_ack_fifo i_r_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (burst_done),
        .data_i  (grant),
        .pop_i   (slv_rack_i),
        .data_o  (head_idx),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

    always_comb begin
        mst_rack_o           = '0;
        mst_rack_o[head_idx] = slv_rack_i && !fifo_empty;
    end

endmodule

`default_nettype wire

/* ace_req_router.sv */
`timescale 1ns/1ps
`default_nettype none

module ace_req_router
    import ace_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      slv_aw_valid_i,
    input  axi_id_t   slv_aw_id_i,
    input  port_idx_t slv_aw_sel_i,
    output logic      slv_aw_ready_o,
    output port_vec_t mst_aw_valid_o,
    output axi_id_t   mst_aw_id_o,
    input  port_vec_t mst_aw_ready_i,
    input  logic      slv_ar_valid_i,
    input  axi_id_t   slv_ar_id_i,
    input  port_idx_t slv_ar_sel_i,
    output logic      slv_ar_ready_o,
    output port_vec_t mst_ar_valid_o,
    output axi_id_t   mst_ar_id_o,
    input  port_vec_t mst_ar_ready_i
);

    // Channel 0 is AW, channel 1 is AR
    logic      [NUM_REQ_CH-1:0] in_valid;
    logic      [NUM_REQ_CH-1:0] in_ready;
    axi_id_t   [NUM_REQ_CH-1:0] in_id;
    port_idx_t [NUM_REQ_CH-1:0] in_sel;
    port_vec_t [NUM_REQ_CH-1:0] out_valid;
    port_vec_t [NUM_REQ_CH-1:0] out_ready;
    axi_id_t   [NUM_REQ_CH-1:0] out_id;

    assign in_valid  = {slv_ar_valid_i, slv_aw_valid_i};
    assign in_id     = {slv_ar_id_i, slv_aw_id_i};
    assign in_sel    = {slv_ar_sel_i, slv_aw_sel_i};
    assign out_ready = {mst_ar_ready_i, mst_aw_ready_i};

    for (genvar c = 0; c < NUM_REQ_CH; c++) begin : gen_spill
        logic      valid_q;
        axi_id_t   id_q;
        port_idx_t sel_q;
        logic      drain;
        logic      load;

        assign drain       = valid_q && out_ready[c][sel_q];
        assign in_ready[c] = !valid_q || drain;
        assign load        = in_valid[c] && in_ready[c];

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                valid_q <= 1'b0;
            end else if (load) begin
                valid_q <= 1'b1;
            end else if (drain) begin
                valid_q <= 1'b0;
            end
        end

        always_ff @(posedge clk_i) begin
            if (load) begin
                id_q  <= in_id[c];
                sel_q <= in_sel[c];
            end
        end

        // Decode onto the selected port only
        assign out_valid[c] = valid_q ? (port_vec_t'(1) << sel_q) : '0;
        assign out_id[c]    = id_q;
    end

    assign slv_aw_ready_o = in_ready[0];
    assign slv_ar_ready_o = in_ready[1];
    assign mst_aw_valid_o = out_valid[0];
    assign mst_ar_valid_o = out_valid[1];
    assign mst_aw_id_o    = out_id[0];
    assign mst_ar_id_o    = out_id[1];

endmodule

`default_nettype wire

/* ace_demux.sv */
`timescale 1ns/1ps
`default_nettype none

module ace_demux
    import ace_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // Upstream requests
    input  logic                          slv_aw_valid_i,
    output logic                          slv_aw_ready_o,
    input  axi_id_t                       slv_aw_id_i,
    input  port_idx_t                     slv_aw_sel_i,
    input  logic                          slv_ar_valid_i,
    output logic                          slv_ar_ready_o,
    input  axi_id_t                       slv_ar_id_i,
    input  port_idx_t                     slv_ar_sel_i,
    // Downstream requests
    output port_vec_t                     mst_aw_valid_o,
    output axi_id_t                       mst_aw_id_o,
    input  port_vec_t                     mst_aw_ready_i,
    output port_vec_t                     mst_ar_valid_o,
    output axi_id_t                       mst_ar_id_o,
    input  port_vec_t                     mst_ar_ready_i,
    // Downstream responses
    input  port_vec_t                     mst_b_valid_i,
    output port_vec_t                     mst_b_ready_o,
    input  axi_id_t   [NUM_MST_PORTS-1:0] mst_b_id_i,
    input  port_vec_t                     mst_r_valid_i,
    output port_vec_t                     mst_r_ready_o,
    input  axi_id_t   [NUM_MST_PORTS-1:0] mst_r_id_i,
    input  axi_data_t [NUM_MST_PORTS-1:0] mst_r_data_i,
    input  port_vec_t                     mst_r_last_i,
    // Upstream responses
    output logic                          slv_b_valid_o,
    input  logic                          slv_b_ready_i,
    output axi_id_t                       slv_b_id_o,
    output logic                          slv_r_valid_o,
    input  logic                          slv_r_ready_i,
    output axi_id_t                       slv_r_id_o,
    output axi_data_t                     slv_r_data_o,
    output logic                          slv_r_last_o,
    // Acknowledges
    input  logic                          slv_wack_i,
    input  logic                          slv_rack_i,
    output port_vec_t                     mst_wack_o,
    output port_vec_t                     mst_rack_o
);

    ace_req_router i_req_router (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .slv_aw_valid_i (slv_aw_valid_i),
        .slv_aw_id_i    (slv_aw_id_i),
        .slv_aw_sel_i   (slv_aw_sel_i),
        .slv_aw_ready_o (slv_aw_ready_o),
        .mst_aw_valid_o (mst_aw_valid_o),
        .mst_aw_id_o    (mst_aw_id_o),
        .mst_aw_ready_i (mst_aw_ready_i),
        .slv_ar_valid_i (slv_ar_valid_i),
        .slv_ar_id_i    (slv_ar_id_i),
        .slv_ar_sel_i   (slv_ar_sel_i),
        .slv_ar_ready_o (slv_ar_ready_o),
        .mst_ar_valid_o (mst_ar_valid_o),
        .mst_ar_id_o    (mst_ar_id_o),
        .mst_ar_ready_i (mst_ar_ready_i)
    );

    ace_write_resp_path i_write_path (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .mst_b_valid_i  (mst_b_valid_i),
        .mst_b_id_i     (mst_b_id_i),
        .mst_b_ready_o  (mst_b_ready_o),
        .slv_b_valid_o  (slv_b_valid_o),
        .slv_b_ready_i  (slv_b_ready_i),
        .slv_b_id_o     (slv_b_id_o),
        .slv_wack_i     (slv_wack_i),
        .mst_wack_o     (mst_wack_o)
    );

    ace_read_resp_path i_read_path (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .mst_r_valid_i  (mst_r_valid_i),
        .mst_r_id_i     (mst_r_id_i),
        .mst_r_data_i   (mst_r_data_i),
        .mst_r_last_i   (mst_r_last_i),
        .mst_r_ready_o  (mst_r_ready_o),
        .slv_r_valid_o  (slv_r_valid_o),
        .slv_r_ready_i  (slv_r_ready_i),
        .slv_r_id_o     (slv_r_id_o),
        .slv_r_data_o   (slv_r_data_o),
        .slv_r_last_o   (slv_r_last_o),
        .slv_rack_i     (slv_rack_i),
        .mst_rack_o     (mst_rack_o)
    );

endmodule

`default_nettype wire

/* tb_ace_demux.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ace_demux
    import ace_pkg::*;
();

    localparam int unsigned NUM_WR         = 400;
    localparam int unsigned NUM_RD         = 400;
    localparam int unsigned TIMEOUT_CYCLES = 20 * (NUM_WR + NUM_RD);

    logic      clk;
    logic      rst_n;

    // Upstream requests
    logic      aw_valid;
    logic      aw_ready;
    axi_id_t   aw_id;
    port_idx_t aw_sel;
    logic      ar_valid;
    logic      ar_ready;
    axi_id_t   ar_id;
    port_idx_t ar_sel;

    // Downstream requests
    port_vec_t dn_aw_valid;
    axi_id_t   dn_aw_id;
    port_vec_t dn_aw_ready;
    port_vec_t dn_ar_valid;
    axi_id_t   dn_ar_id;
    port_vec_t dn_ar_ready;

    // Downstream responses
    port_vec_t                     b_valid;
    port_vec_t                     b_ready;
    axi_id_t   [NUM_MST_PORTS-1:0] b_id;
    port_vec_t                     r_valid;
    port_vec_t                     r_ready;
    port_vec_t                     r_last;
    axi_id_t   [NUM_MST_PORTS-1:0] r_id;
    axi_data_t [NUM_MST_PORTS-1:0] r_data;

    // Upstream responses and acks
    logic      up_b_valid;
    logic      up_b_ready;
    axi_id_t   up_b_id;
    logic      up_r_valid;
    logic      up_r_ready;
    axi_id_t   up_r_id;
    axi_data_t up_r_data;
    logic      up_r_last;
    logic      wack;
    logic      rack;
    port_vec_t wack_vec;
    port_vec_t rack_vec;

    // Reference model
    port_idx_t   aw_exp_sel [$];
    axi_id_t     aw_exp_id [$];
    port_idx_t   ar_exp_sel [$];
    axi_id_t     ar_exp_id [$];
    axi_id_t     b_pend [NUM_MST_PORTS][$];
    axi_id_t     r_pend [NUM_MST_PORTS][$];
    port_idx_t   wack_q [$];
    port_idx_t   rack_q [$];
    int unsigned r_len [NUM_MST_PORTS];
    int unsigned r_beat [NUM_MST_PORTS];
    logic [7:0]  r_seq [NUM_MST_PORTS];
    logic        r_open;
    port_idx_t   r_open_port;
    logic        aw_fire;
    logic        ar_fire;
    port_vec_t   b_fire;
    port_vec_t   r_fire;
    int unsigned aw_sent;
    int unsigned ar_sent;
    int unsigned b_done;
    int unsigned r_done;
    int unsigned b_stall_seen;
    int unsigned r_stall_seen;
    int unsigned cycle;

    ace_demux dut0 (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .slv_aw_valid_i (aw_valid),
        .slv_aw_ready_o (aw_ready),
        .slv_aw_id_i    (aw_id),
        .slv_aw_sel_i   (aw_sel),
        .slv_ar_valid_i (ar_valid),
        .slv_ar_ready_o (ar_ready),
        .slv_ar_id_i    (ar_id),
        .slv_ar_sel_i   (ar_sel),
        .mst_aw_valid_o (dn_aw_valid),
        .mst_aw_id_o    (dn_aw_id),
        .mst_aw_ready_i (dn_aw_ready),
        .mst_ar_valid_o (dn_ar_valid),
        .mst_ar_id_o    (dn_ar_id),
        .mst_ar_ready_i (dn_ar_ready),
        .mst_b_valid_i  (b_valid),
        .mst_b_ready_o  (b_ready),
        .mst_b_id_i     (b_id),
        .mst_r_valid_i  (r_valid),
        .mst_r_ready_o  (r_ready),
        .mst_r_id_i     (r_id),
        .mst_r_data_i   (r_data),
        .mst_r_last_i   (r_last),
        .slv_b_valid_o  (up_b_valid),
        .slv_b_ready_i  (up_b_ready),
        .slv_b_id_o     (up_b_id),
        .slv_r_valid_o  (up_r_valid),
        .slv_r_ready_i  (up_r_ready),
        .slv_r_id_o     (up_r_id),
        .slv_r_data_o   (up_r_data),
        .slv_r_last_o   (up_r_last),
        .slv_wack_i     (wack),
        .slv_rack_i     (rack),
        .mst_wack_o     (wack_vec),
        .mst_rack_o     (rack_vec)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    function automatic port_vec_t onehot(port_idx_t p);
        return port_vec_t'(1) << p;
    endfunction

    function automatic port_idx_t first_set(port_vec_t v);
        port_idx_t idx;
        idx = '0;
        for (int i = NUM_MST_PORTS - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = port_idx_t'(i);
            end
        end
        return idx;
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_port(string name, port_idx_t exp, port_idx_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[ERROR] time %0t %s expected %0d actual %0d",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_id(string name, axi_id_t exp, axi_id_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[ERROR] time %0t %s expected %0h actual %0h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_data(string name, axi_data_t exp, axi_data_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[ERROR] time %0t %s expected %08h actual %08h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_vec(string name, port_vec_t exp, port_vec_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[ERROR] time %0t %s expected %b actual %b",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("[ERROR] time %0t %s expected %b actual %b",
                                    $time, name, exp, act));
        end
    endtask

    // Called 1 ns after the rising edge
    task automatic drive_inputs();
        if (aw_fire) begin
            aw_valid = 1'b0;
        end
        if (!aw_valid && aw_sent < NUM_WR && ($urandom() % 2) == 0) begin
            aw_valid = 1'b1;
            aw_id    = axi_id_t'($urandom());
            aw_sel   = port_idx_t'($urandom());
            aw_sent++;
        end
        if (ar_fire) begin
            ar_valid = 1'b0;
        end
        if (!ar_valid && ar_sent < NUM_RD && ($urandom() % 2) == 0) begin
            ar_valid = 1'b1;
            ar_id    = axi_id_t'($urandom());
            ar_sel   = port_idx_t'($urandom());
            ar_sent++;
        end
        dn_aw_ready = port_vec_t'($urandom());
        dn_ar_ready = port_vec_t'($urandom());

        for (int p = 0; p < NUM_MST_PORTS; p++) begin
            if (b_fire[p]) begin
                b_valid[p] = 1'b0;
            end
            if (!b_valid[p] && b_pend[p].size() > 0 && ($urandom() % 3) == 0) begin
                b_valid[p] = 1'b1;
                b_id[p]    = b_pend[p].pop_front();
            end
            if (r_fire[p]) begin
                r_valid[p] = 1'b0;
                if (r_last[p]) begin
                    void'(r_pend[p].pop_front());
                    r_len[p] = 0;
                end else begin
                    r_beat[p]++;
                end
            end
            // Gaps between beats are allowed
            if (!r_valid[p] && ($urandom() % 3) == 0) begin
                if (r_len[p] == 0 && r_pend[p].size() > 0) begin
                    r_len[p]  = 1 + $urandom() % 4;
                    r_beat[p] = 0;
                    r_seq[p]++;
                end
                if (r_len[p] != 0) begin
                    r_valid[p] = 1'b1;
                    r_id[p]    = r_pend[p][0];
                    r_last[p]  = (r_beat[p] == r_len[p] - 1);
                    r_data[p]  = {16'hDA7A, 4'(p), 4'(r_beat[p]), r_seq[p]};
                end
            end
        end

        up_b_ready = ($urandom() % 4) != 0;
        up_r_ready = ($urandom() % 4) != 0;
        // Alternate between withheld and frequent acks to fill the queues
        if (((cycle / 64) % 2) == 0) begin
            wack = 1'b0;
            rack = 1'b0;
        end else begin
            wack = ($urandom() % 2) == 0;
            rack = ($urandom() % 2) == 0;
        end
    endtask

    // Called at the falling edge, where every DUT output is settled
    task automatic sample_and_check();
        port_idx_t p;

        aw_fire = aw_valid && aw_ready;
        ar_fire = ar_valid && ar_ready;
        b_fire  = b_valid & b_ready;
        r_fire  = r_valid & r_ready;

        // Spill register holds at most the oldest accepted request
        if (aw_exp_sel.size() > 0) begin
            check_bit("slv_aw_ready_o", dn_aw_ready[aw_exp_sel[0]], aw_ready);
            check_vec("mst_aw_valid_o", onehot(aw_exp_sel[0]), dn_aw_valid);
            check_id("mst_aw_id_o", aw_exp_id[0], dn_aw_id);
            if ((dn_aw_valid & dn_aw_ready) != '0) begin
                b_pend[aw_exp_sel[0]].push_back(aw_exp_id.pop_front());
                void'(aw_exp_sel.pop_front());
            end
        end else begin
            check_bit("slv_aw_ready_o", 1'b1, aw_ready);
            check_vec("mst_aw_valid_o", '0, dn_aw_valid);
        end
        if (aw_fire) begin
            aw_exp_sel.push_back(aw_sel);
            aw_exp_id.push_back(aw_id);
        end

        if (ar_exp_sel.size() > 0) begin
            check_bit("slv_ar_ready_o", dn_ar_ready[ar_exp_sel[0]], ar_ready);
            check_vec("mst_ar_valid_o", onehot(ar_exp_sel[0]), dn_ar_valid);
            check_id("mst_ar_id_o", ar_exp_id[0], dn_ar_id);
            if ((dn_ar_valid & dn_ar_ready) != '0) begin
                r_pend[ar_exp_sel[0]].push_back(ar_exp_id.pop_front());
                void'(ar_exp_sel.pop_front());
            end
        end else begin
            check_bit("slv_ar_ready_o", 1'b1, ar_ready);
            check_vec("mst_ar_valid_o", '0, dn_ar_valid);
        end
        if (ar_fire) begin
            ar_exp_sel.push_back(ar_sel);
            ar_exp_id.push_back(ar_id);
        end

        // Write responses
        if (wack_q.size() == MAX_TRANS && b_valid != '0) begin
            b_stall_seen++;
        end
        check_bit("slv_b_valid_o", (b_valid != '0) && (wack_q.size() < MAX_TRANS), up_b_valid);
        if (wack && wack_q.size() > 0) begin
            check_vec("mst_wack_o", onehot(wack_q.pop_front()), wack_vec);
        end else begin
            check_vec("mst_wack_o", '0, wack_vec);
        end
        if (up_b_valid && up_b_ready) begin
            p = first_set(b_ready);
            check_vec("mst_b_ready_o", onehot(p), b_ready);
            if (!b_valid[p]) begin
                stop_on_error("B response accepted from a port with no pending response");
            end
            check_id("slv_b_id_o", b_id[p], up_b_id);
            wack_q.push_back(p);
            b_done++;
        end else begin
            check_vec("mst_b_ready_o", '0, b_ready);
        end

        // Burst lock keeps one port until last
        if (rack_q.size() == MAX_TRANS && r_valid != '0) begin
            r_stall_seen++;
        end
        check_bit("slv_r_valid_o",
                  (rack_q.size() < MAX_TRANS) &&
                  (r_open ? r_valid[r_open_port] : (r_valid != '0)), up_r_valid);
        if (rack && rack_q.size() > 0) begin
            check_vec("mst_rack_o", onehot(rack_q.pop_front()), rack_vec);
        end else begin
            check_vec("mst_rack_o", '0, rack_vec);
        end
        if (up_r_valid && up_r_ready) begin
            p = port_idx_t'(up_r_data[15:12]);
            if (r_open) begin
                check_port("slv_r burst port", r_open_port, p);
            end
            check_vec("mst_r_ready_o", onehot(p), r_ready);
            if (!r_valid[p]) begin
                stop_on_error("R beat accepted from a port with no pending beat");
            end
            check_id("slv_r_id_o", r_id[p], up_r_id);
            check_data("slv_r_data_o", r_data[p], up_r_data);
            check_bit("slv_r_last_o", r_last[p], up_r_last);
            r_open      = !up_r_last;
            r_open_port = p;
            if (up_r_last) begin
                rack_q.push_back(p);
                r_done++;
            end
        end else begin
            check_vec("mst_r_ready_o", '0, r_ready);
        end
    endtask

    initial begin
        void'($urandom(32'h3452));
        rst_n        = 1'b0;
        aw_valid     = 1'b0;
        aw_id        = '0;
        aw_sel       = '0;
        ar_valid     = 1'b0;
        ar_id        = '0;
        ar_sel       = '0;
        dn_aw_ready  = '0;
        dn_ar_ready  = '0;
        b_valid      = '0;
        b_id         = '0;
        r_valid      = '0;
        r_id         = '0;
        r_data       = '0;
        r_last       = '0;
        up_b_ready   = 1'b0;
        up_r_ready   = 1'b0;
        wack         = 1'b0;
        rack         = 1'b0;
        aw_fire      = 1'b0;
        ar_fire      = 1'b0;
        b_fire       = '0;
        r_fire       = '0;
        r_open       = 1'b0;
        r_open_port  = '0;
        aw_sent      = 0;
        ar_sent      = 0;
        b_done       = 0;
        r_done       = 0;
        b_stall_seen = 0;
        r_stall_seen = 0;
        cycle        = 0;
        for (int p = 0; p < NUM_MST_PORTS; p++) begin
            r_len[p]  = 0;
            r_beat[p] = 0;
            r_seq[p]  = '0;
        end

        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        // State straight out of reset
        @(negedge clk);
        check_vec("mst_aw_valid_o", '0, dn_aw_valid);
        check_vec("mst_ar_valid_o", '0, dn_ar_valid);
        check_bit("slv_b_valid_o", 1'b0, up_b_valid);
        check_bit("slv_r_valid_o", 1'b0, up_r_valid);
        check_vec("mst_wack_o", '0, wack_vec);
        check_vec("mst_rack_o", '0, rack_vec);

        while (!(b_done == NUM_WR && r_done == NUM_RD &&
                 wack_q.size() == 0 && rack_q.size() == 0)) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            sample_and_check();
            cycle++;
            if (cycle > TIMEOUT_CYCLES) begin
                stop_on_error("Timeout, not all transactions and acknowledges completed");
            end
        end

        if (b_stall_seen == 0 || r_stall_seen == 0) begin
            stop_on_error("An acknowledge queue never filled while responses were waiting");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* ace_demux.f */
ace_pkg.sv
ace_ack_fifo.sv
ace_resp_arbiter.sv
ace_write_resp_path.sv
ace_read_resp_path.sv
ace_req_router.sv
ace_demux.sv
tb_ace_demux.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ace_demux
FILELIST  ?= ace_demux.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
